// File: rtl/axil_mon_consts.svh
/* Bus widths, outstanding count depth and timer limits
   Bit positions of the violation flag vector */
`ifndef AXIL_MON_CONSTS_SVH
`define AXIL_MON_CONSTS_SVH

// AXI-lite bus widths
`define AXIL_ADDR_W     28
`define AXIL_DATA_W     32
`define AXIL_STRB_W     (`AXIL_DATA_W / 8)

// Outstanding counter width, legal maximum is one below all ones
`define AXIL_LGDEPTH    4

// Timer limits in cycles
`define AXIL_MAXWAIT    12
`define AXIL_MAXRSTALL  12
`define AXIL_MAXDELAY   12
`define AXIL_TIMER_W    4

// Violation flag positions
`define VIO_RESP_EXOKAY 0
`define VIO_RESET_VALID 1
`define VIO_HOLD_AW     2
`define VIO_HOLD_W      3
`define VIO_HOLD_AR     4
`define VIO_HOLD_B      5
`define VIO_HOLD_R      6
`define VIO_OVERFLOW    7
`define VIO_ORPHAN_RESP 8
`define VIO_REQ_STALL   9
`define VIO_RESP_STALL  10
`define VIO_RESP_DELAY  11
`define VIO_COUNT       12

`endif

// File: rtl/axil_mon_pkg.sv
/* Shared vector types of the AXI-lite monitor */
`include "axil_mon_consts.svh"

package axil_mon_pkg;

	// Address channel payload
	typedef logic [`AXIL_ADDR_W-1:0] addr_t;

	// Protection bits of AW and AR
	typedef logic [2:0] prot_t;

	// Data word of W and R
	typedef logic [`AXIL_DATA_W-1:0] data_t;

	// One strobe per data byte
	typedef logic [`AXIL_STRB_W-1:0] strb_t;

	// Response code of B and R
	// 00 OKAY, 01 EXOKAY, 10 SLVERR, 11 DECERR
	typedef logic [1:0] resp_t;

	// Outstanding transaction count
	typedef logic [`AXIL_LGDEPTH-1:0] depth_t;

	// Stall and delay timer
	typedef logic [`AXIL_TIMER_W-1:0] timer_t;

	// Sticky violation flags
	// One bit per rule at the VIO_* positions
	typedef logic [`VIO_COUNT-1:0] vio_t;

endpackage

// File: rtl/axil_event_if.sv
/* Per-cycle handshake events and raw channel levels
   Modports for the watcher, the count tracker and the timers */
`timescale 1ns/100ps

interface axil_event_if;

	// Handshake strobes, only out of reset
	logic ar_req;
	logic aw_req;
	logic w_req;
	logic rd_ack;
	logic wr_ack;

	// Raw valid and ready levels
	logic awvalid;
	logic wvalid;
	logic arvalid;
	logic bvalid;
	logic rvalid;
	logic bready;
	logic rready;
	logic awready;
	logic wready;
	logic arready;

	modport watch (output ar_req, aw_req, w_req, rd_ack, wr_ack, awvalid, wvalid,
		arvalid, bvalid, rvalid, bready, rready, awready, wready, arready);
	modport track (input ar_req, aw_req, w_req, rd_ack, wr_ack, bvalid, rvalid,
		awready, wready, arready);
	modport timer (input awvalid, wvalid, arvalid, bvalid, rvalid, bready, rready,
		awready, wready, arready);

endinterface

// File: rtl/axil_channel_watch.sv
/* AXI-lite channel watcher
   Handshake event generation, reset, hold and response code checks */
`timescale 1ns/100ps
`include "axil_mon_consts.svh"

module axil_channel_watch
(
	input  logic                i_clk,
	input  logic                i_axi_reset_n,
	input  logic                i_axi_awvalid,
	input  logic                i_axi_awready,
	input  axil_mon_pkg::addr_t i_axi_awaddr,
	input  axil_mon_pkg::prot_t i_axi_awprot,
	input  logic                i_axi_wvalid,
	input  logic                i_axi_wready,
	input  axil_mon_pkg::data_t i_axi_wdata,
	input  axil_mon_pkg::strb_t i_axi_wstrb,
	input  logic                i_axi_bvalid,
	input  logic                i_axi_bready,
	input  axil_mon_pkg::resp_t i_axi_bresp,
	input  logic                i_axi_arvalid,
	input  logic                i_axi_arready,
	input  axil_mon_pkg::addr_t i_axi_araddr,
	input  axil_mon_pkg::prot_t i_axi_arprot,
	input  logic                i_axi_rvalid,
	input  logic                i_axi_rready,
	input  axil_mon_pkg::data_t i_axi_rdata,
	input  axil_mon_pkg::resp_t i_axi_rresp,
	axil_event_if.watch         o_ev,
	output axil_mon_pkg::vio_t  o_vio_chan
);

	// Stalled at the last edge, order is aw w ar b r
	logic [4:0]          stall_q;
	logic                out_of_rst;
	axil_mon_pkg::addr_t awaddr_q;
	axil_mon_pkg::prot_t awprot_q;
	axil_mon_pkg::data_t wdata_q;
	axil_mon_pkg::strb_t wstrb_q;
	axil_mon_pkg::addr_t araddr_q;
	axil_mon_pkg::prot_t arprot_q;
	axil_mon_pkg::resp_t bresp_q;
	axil_mon_pkg::data_t rdata_q;
	axil_mon_pkg::resp_t rresp_q;
	axil_mon_pkg::vio_t  chan_hit;

	//////////////////////////////////////////////////
	// Event strobes
	//////////////////////////////////////////////////

	// A transfer needs valid and ready together with reset released
	assign o_ev.aw_req  = i_axi_awvalid && i_axi_awready && i_axi_reset_n;
	assign o_ev.w_req   = i_axi_wvalid && i_axi_wready && i_axi_reset_n;
	assign o_ev.ar_req  = i_axi_arvalid && i_axi_arready && i_axi_reset_n;
	assign o_ev.wr_ack  = i_axi_bvalid && i_axi_bready && i_axi_reset_n;
	assign o_ev.rd_ack  = i_axi_rvalid && i_axi_rready && i_axi_reset_n;

	// Raw levels for the tracker and the timers
	assign o_ev.awvalid = i_axi_awvalid;
	assign o_ev.wvalid  = i_axi_wvalid;
	assign o_ev.arvalid = i_axi_arvalid;
	assign o_ev.bvalid  = i_axi_bvalid;
	assign o_ev.rvalid  = i_axi_rvalid;
	assign o_ev.bready  = i_axi_bready;
	assign o_ev.rready  = i_axi_rready;
	assign o_ev.awready = i_axi_awready;
	assign o_ev.wready  = i_axi_wready;
	assign o_ev.arready = i_axi_arready;

	//////////////////////////////////////////////////
	// Stall and payload capture
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			stall_q    <= '0;
			out_of_rst <= 1'b0;
		end
		else
		begin
			stall_q    <= {i_axi_awvalid && !i_axi_awready, i_axi_wvalid && !i_axi_wready,
				i_axi_arvalid && !i_axi_arready, i_axi_bvalid && !i_axi_bready,
				i_axi_rvalid && !i_axi_rready};
			out_of_rst <= 1'b1;
		end
	end

	// Payload snapshot, compared only when the stall flag is set
	always_ff @(posedge i_clk)
	begin
		awaddr_q <= i_axi_awaddr;
		awprot_q <= i_axi_awprot;
		wdata_q  <= i_axi_wdata;
		wstrb_q  <= i_axi_wstrb;
		araddr_q <= i_axi_araddr;
		arprot_q <= i_axi_arprot;
		bresp_q  <= i_axi_bresp;
		rdata_q  <= i_axi_rdata;
		rresp_q  <= i_axi_rresp;
	end

	//////////////////////////////////////////////////
	// Rule checks
	//////////////////////////////////////////////////

	always_comb
	begin
		chan_hit = '0;
		// Reserved exclusive okay code on either response
		chan_hit[`VIO_RESP_EXOKAY] = (i_axi_bvalid && i_axi_bresp == 2'b01)
			|| (i_axi_rvalid && i_axi_rresp == 2'b01);
		// Every valid must be low in the first cycle out of reset
		chan_hit[`VIO_RESET_VALID] = !out_of_rst && (i_axi_awvalid || i_axi_wvalid
			|| i_axi_arvalid || i_axi_bvalid || i_axi_rvalid);
		// A stalled channel keeps valid up and its payload stable
		chan_hit[`VIO_HOLD_AW] = stall_q[4] && (!i_axi_awvalid
			|| i_axi_awaddr != awaddr_q || i_axi_awprot != awprot_q);
		chan_hit[`VIO_HOLD_W]  = stall_q[3] && (!i_axi_wvalid
			|| i_axi_wdata != wdata_q || i_axi_wstrb != wstrb_q);
		chan_hit[`VIO_HOLD_AR] = stall_q[2] && (!i_axi_arvalid
			|| i_axi_araddr != araddr_q || i_axi_arprot != arprot_q);
		chan_hit[`VIO_HOLD_B]  = stall_q[1] && (!i_axi_bvalid || i_axi_bresp != bresp_q);
		chan_hit[`VIO_HOLD_R]  = stall_q[0] && (!i_axi_rvalid
			|| i_axi_rdata != rdata_q || i_axi_rresp != rresp_q);
	end

	// Sticky until reset
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			o_vio_chan <= '0;
		else
			o_vio_chan <= o_vio_chan | chan_hit;
	end

endmodule

// File: rtl/axil_outstanding_track.sv
/* Outstanding read, write address and write data counters
   Overflow and orphan response checks */
`timescale 1ns/100ps
`include "axil_mon_consts.svh"

module axil_outstanding_track
(
	input  logic                 i_clk,
	input  logic                 i_axi_reset_n,
	axil_event_if.track          i_ev,
	output axil_mon_pkg::depth_t o_rd_cnt,
	output axil_mon_pkg::depth_t o_awr_cnt,
	output axil_mon_pkg::depth_t o_wr_cnt,
	output axil_mon_pkg::vio_t   o_vio_cnt
);

	// Count at which a further accept would pass the legal maximum
	axil_mon_pkg::depth_t near_full;
	axil_mon_pkg::vio_t   cnt_hit;

	assign near_full = {{(`AXIL_LGDEPTH-1){1'b1}}, 1'b0};

	// Request adds one and acknowledge takes one
	// Both ends saturate so a bad bus cannot wrap the count
	function automatic axil_mon_pkg::depth_t step(input axil_mon_pkg::depth_t cnt,
		input logic inc, input logic dec);
		case ({inc, dec})
			2'b10:   return (&cnt) ? cnt : cnt + 1'b1;
			2'b01:   return (cnt == '0) ? cnt : cnt - 1'b1;
			default: return cnt;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Counters
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_rd_cnt  <= '0;
			o_awr_cnt <= '0;
			o_wr_cnt  <= '0;
		end
		else
		begin
			o_rd_cnt  <= step(o_rd_cnt, i_ev.ar_req, i_ev.rd_ack);
			// One B response retires both an address and a data beat
			o_awr_cnt <= step(o_awr_cnt, i_ev.aw_req, i_ev.wr_ack);
			o_wr_cnt  <= step(o_wr_cnt, i_ev.w_req, i_ev.wr_ack);
		end
	end

	//////////////////////////////////////////////////
	// Capacity and orphan checks
	//////////////////////////////////////////////////

	always_comb
	begin
		cnt_hit = '0;
		// Full count or ready still high at the last legal slot
		cnt_hit[`VIO_OVERFLOW] = (&o_rd_cnt) || (&o_awr_cnt) || (&o_wr_cnt)
			|| (o_rd_cnt == near_full && i_ev.arready)
			|| (o_awr_cnt == near_full && i_ev.awready)
			|| (o_wr_cnt == near_full && i_ev.wready);
		// Response with nothing to answer
		cnt_hit[`VIO_ORPHAN_RESP] = (i_ev.bvalid && (o_awr_cnt == '0 || o_wr_cnt == '0))
			|| (i_ev.rvalid && o_rd_cnt == '0);
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			o_vio_cnt <= '0;
		else
			o_vio_cnt <= o_vio_cnt | cnt_hit;
	end

	// From zero a count only holds or steps up
	a_rd_no_wrap  : assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		o_rd_cnt == '0 |=> !(&o_rd_cnt));
	a_awr_no_wrap : assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		o_awr_cnt == '0 |=> !(&o_awr_cnt));
	a_wr_no_wrap  : assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		o_wr_cnt == '0 |=> !(&o_wr_cnt));

endmodule

// File: rtl/axil_timeout_check.sv
/* Request stall, response stall and response delay timers
   Limit breach flags */
`timescale 1ns/100ps
`include "axil_mon_consts.svh"

module axil_timeout_check
(
	input  logic                 i_clk,
	input  logic                 i_axi_reset_n,
	axil_event_if.timer          i_ev,
	input  axil_mon_pkg::depth_t i_rd_cnt,
	input  axil_mon_pkg::depth_t i_awr_cnt,
	input  axil_mon_pkg::depth_t i_wr_cnt,
	output axil_mon_pkg::vio_t   o_vio_time
);

	axil_mon_pkg::timer_t lim_wait;
	axil_mon_pkg::timer_t lim_rstall;
	axil_mon_pkg::timer_t lim_delay;
	// Timers
	axil_mon_pkg::timer_t aw_stall;
	axil_mon_pkg::timer_t w_stall;
	axil_mon_pkg::timer_t ar_stall;
	axil_mon_pkg::timer_t b_stall;
	axil_mon_pkg::timer_t r_stall;
	axil_mon_pkg::timer_t wr_delay;
	axil_mon_pkg::timer_t rd_delay;
	// Qualifying cycle for each timer
	logic aw_run;
	logic w_run;
	logic ar_run;
	logic b_run;
	logic r_run;
	logic wr_run;
	logic rd_run;
	axil_mon_pkg::vio_t   time_hit;

	assign lim_wait   = axil_mon_pkg::timer_t'(`AXIL_MAXWAIT);
	assign lim_rstall = axil_mon_pkg::timer_t'(`AXIL_MAXRSTALL);
	assign lim_delay  = axil_mon_pkg::timer_t'(`AXIL_MAXDELAY);

	// Count qualifying cycles and hold at the limit
	function automatic axil_mon_pkg::timer_t tick(input axil_mon_pkg::timer_t t,
		input logic run, input axil_mon_pkg::timer_t lim);
		if (!run)
			return '0;
		return (t >= lim) ? lim : t + 1'b1;
	endfunction

	// True on the cycle that brings the timer to its limit
	function automatic logic at_limit(input axil_mon_pkg::timer_t t,
		input logic run, input axil_mon_pkg::timer_t lim);
		return run && (t >= lim - 1'b1);
	endfunction

	//////////////////////////////////////////////////
	// Qualifying cycles
	//////////////////////////////////////////////////

	// A pending B response may back up the write channels
	// A channel ahead of an idle partner is waiting and not stalled
	assign aw_run = i_ev.awvalid && !i_ev.awready && !i_ev.bvalid
		&& !(i_awr_cnt >= i_wr_cnt && !i_ev.wvalid);
	assign w_run  = i_ev.wvalid && !i_ev.wready && !i_ev.bvalid
		&& !(i_wr_cnt >= i_awr_cnt && !i_ev.awvalid);
	assign ar_run = i_ev.arvalid && !i_ev.arready && !i_ev.rvalid;
	// Response held back by the master
	assign b_run  = i_ev.bvalid && !i_ev.bready;
	assign r_run  = i_ev.rvalid && !i_ev.rready;
	// Complete write or read waiting with no response offered
	assign wr_run = i_awr_cnt != '0 && i_wr_cnt != '0 && !i_ev.bvalid;
	assign rd_run = i_rd_cnt != '0 && !i_ev.rvalid;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			aw_stall <= '0;
			w_stall  <= '0;
			ar_stall <= '0;
			b_stall  <= '0;
			r_stall  <= '0;
			wr_delay <= '0;
			rd_delay <= '0;
		end
		else
		begin
			aw_stall <= tick(aw_stall, aw_run, lim_wait);
			w_stall  <= tick(w_stall, w_run, lim_wait);
			ar_stall <= tick(ar_stall, ar_run, lim_wait);
			b_stall  <= tick(b_stall, b_run, lim_rstall);
			r_stall  <= tick(r_stall, r_run, lim_rstall);
			wr_delay <= tick(wr_delay, wr_run, lim_delay);
			rd_delay <= tick(rd_delay, rd_run, lim_delay);
		end
	end

	//////////////////////////////////////////////////
	// Limit flags
	//////////////////////////////////////////////////

	always_comb
	begin
		time_hit = '0;
		time_hit[`VIO_REQ_STALL]  = at_limit(aw_stall, aw_run, lim_wait)
			|| at_limit(w_stall, w_run, lim_wait) || at_limit(ar_stall, ar_run, lim_wait);
		time_hit[`VIO_RESP_STALL] = at_limit(b_stall, b_run, lim_rstall)
			|| at_limit(r_stall, r_run, lim_rstall);
		time_hit[`VIO_RESP_DELAY] = at_limit(wr_delay, wr_run, lim_delay)
			|| at_limit(rd_delay, rd_run, lim_delay);
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			o_vio_time <= '0;
		else
			o_vio_time <= o_vio_time | time_hit;
	end

	// No timer runs past its limit so the flag can never be skipped
	a_timer_bound : assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		aw_stall <= lim_wait && w_stall <= lim_wait && ar_stall <= lim_wait
		&& b_stall <= lim_rstall && r_stall <= lim_rstall
		&& wr_delay <= lim_delay && rd_delay <= lim_delay);

endmodule

// File: rtl/axil_monitor.sv
/* Passive AXI-lite slave port monitor top level
   Plain bus ports, sub-block instances and violation vector */
`timescale 1ns/100ps

module axil_monitor
(
	input  logic                 i_clk,
	input  logic                 i_axi_reset_n,
	// Write address channel
	input  logic                 i_axi_awvalid,
	input  logic                 i_axi_awready,
	input  axil_mon_pkg::addr_t  i_axi_awaddr,
	input  axil_mon_pkg::prot_t  i_axi_awprot,
	// Write data channel
	input  logic                 i_axi_wvalid,
	input  logic                 i_axi_wready,
	input  axil_mon_pkg::data_t  i_axi_wdata,
	input  axil_mon_pkg::strb_t  i_axi_wstrb,
	// Write response channel
	input  logic                 i_axi_bvalid,
	input  logic                 i_axi_bready,
	input  axil_mon_pkg::resp_t  i_axi_bresp,
	// Read address channel
	input  logic                 i_axi_arvalid,
	input  logic                 i_axi_arready,
	input  axil_mon_pkg::addr_t  i_axi_araddr,
	input  axil_mon_pkg::prot_t  i_axi_arprot,
	// Read data channel
	input  logic                 i_axi_rvalid,
	input  logic                 i_axi_rready,
	input  axil_mon_pkg::data_t  i_axi_rdata,
	input  axil_mon_pkg::resp_t  i_axi_rresp,
	// Live counts and sticky flags
	output axil_mon_pkg::depth_t o_rd_outstanding,
	output axil_mon_pkg::depth_t o_awr_outstanding,
	output axil_mon_pkg::depth_t o_wr_outstanding,
	output axil_mon_pkg::vio_t   o_violation
);

	axil_mon_pkg::vio_t vio_chan;
	axil_mon_pkg::vio_t vio_cnt;
	axil_mon_pkg::vio_t vio_time;

	axil_event_if ev_if ();

	// Bus ports share their names with the top level
	axil_channel_watch u_watch (
		.*,
		.o_ev       (ev_if.watch),
		.o_vio_chan (vio_chan)
	);

	axil_outstanding_track u_track (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_ev          (ev_if.track),
		.o_rd_cnt      (o_rd_outstanding),
		.o_awr_cnt     (o_awr_outstanding),
		.o_wr_cnt      (o_wr_outstanding),
		.o_vio_cnt     (vio_cnt)
	);

	// Timers see the registered counts
	axil_timeout_check u_timeout (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_ev          (ev_if.timer),
		.i_rd_cnt      (o_rd_outstanding),
		.i_awr_cnt     (o_awr_outstanding),
		.i_wr_cnt      (o_wr_outstanding),
		.o_vio_time    (vio_time)
	);

	// Each block owns disjoint bits
	assign o_violation = vio_chan | vio_cnt | vio_time;

endmodule

// File: dv/tb_clk_gen.sv
/* Testbench clock and power-on reset generator */
`timescale 1ns/100ps

module tb_clk_gen
(
	output logic o_clk,
	output logic o_rst_n
);

	// 4 ns period
	initial
	begin
		o_clk = 1'b0;
		forever
			#2 o_clk = ~o_clk;
	end

	// Reset low for five cycles, released on a falling edge
	initial
	begin
		o_rst_n = 1'b0;
		repeat (5) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

// File: dv/axil_monitor_tb.sv
/* AXI-lite monitor testbench
   Master and slave stimulus, reference counts, assertions and watchdog */
`timescale 1ns/100ps
`include "axil_mon_consts.svh"

module axil_monitor_tb;

	// Clean traffic worst case plus rule tests, in cycles
	localparam int TEST_CYCLES = 40 * 32 + 400;
	localparam int WATCHDOG_NS = (TEST_CYCLES + 500) * 4;

	logic clk;
	logic gen_rst_n;
	logic tb_rst_n;
	logic rst_n;
	int   seed;
	int   errors;
	axil_mon_pkg::vio_t   allowed;
	axil_mon_pkg::depth_t ref_rd;
	axil_mon_pkg::depth_t ref_awr;
	axil_mon_pkg::depth_t ref_wr;
	// Bus
	logic awvalid;
	logic awready;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic rready;
	axil_mon_pkg::addr_t awaddr;
	axil_mon_pkg::addr_t araddr;
	axil_mon_pkg::prot_t awprot;
	axil_mon_pkg::prot_t arprot;
	axil_mon_pkg::data_t wdata;
	axil_mon_pkg::data_t rdata;
	axil_mon_pkg::strb_t wstrb;
	axil_mon_pkg::resp_t bresp;
	axil_mon_pkg::resp_t rresp;
	axil_mon_pkg::depth_t o_rd_outstanding;
	axil_mon_pkg::depth_t o_awr_outstanding;
	axil_mon_pkg::depth_t o_wr_outstanding;
	axil_mon_pkg::vio_t   o_violation;

	tb_clk_gen u_clk_gen (.o_clk(clk), .o_rst_n(gen_rst_n));

	assign rst_n = gen_rst_n && tb_rst_n;

	axil_monitor UUT (
		.i_clk(clk), .i_axi_reset_n(rst_n),
		.i_axi_awvalid(awvalid), .i_axi_awready(awready),
		.i_axi_awaddr(awaddr), .i_axi_awprot(awprot),
		.i_axi_wvalid(wvalid), .i_axi_wready(wready),
		.i_axi_wdata(wdata), .i_axi_wstrb(wstrb),
		.i_axi_bvalid(bvalid), .i_axi_bready(bready), .i_axi_bresp(bresp),
		.i_axi_arvalid(arvalid), .i_axi_arready(arready),
		.i_axi_araddr(araddr), .i_axi_arprot(arprot),
		.i_axi_rvalid(rvalid), .i_axi_rready(rready),
		.i_axi_rdata(rdata), .i_axi_rresp(rresp),
		.o_rd_outstanding(o_rd_outstanding),
		.o_awr_outstanding(o_awr_outstanding),
		.o_wr_outstanding(o_wr_outstanding),
		.o_violation(o_violation)
	);

	//////////////////////////////////////////////////
	// Reference counts
	//////////////////////////////////////////////////

	// Accept adds one, response takes one, never below zero
	function automatic axil_mon_pkg::depth_t next_count(input axil_mon_pkg::depth_t cnt,
		input logic add, input logic sub);
		if (add && !sub)
			return cnt + 1'b1;
		if (sub && !add && cnt != '0)
			return cnt - 1'b1;
		return cnt;
	endfunction

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ref_rd  <= '0;
			ref_awr <= '0;
			ref_wr  <= '0;
		end
		else
		begin
			ref_rd  <= next_count(ref_rd, arvalid && arready, rvalid && rready);
			ref_awr <= next_count(ref_awr, awvalid && awready, bvalid && bready);
			ref_wr  <= next_count(ref_wr, wvalid && wready, bvalid && bready);
		end
	end

	// Outputs are registered, so the falling edge sees them settled
	a_rd_cnt : assert property (@(negedge clk) o_rd_outstanding == ref_rd)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] o_rd_outstanding: got %h expected %h", o_rd_outstanding, ref_rd);
		end
	a_awr_cnt : assert property (@(negedge clk) o_awr_outstanding == ref_awr)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] o_awr_outstanding: got %h expected %h", o_awr_outstanding,
				ref_awr);
		end
	a_wr_cnt : assert property (@(negedge clk) o_wr_outstanding == ref_wr)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] o_wr_outstanding: got %h expected %h", o_wr_outstanding, ref_wr);
		end
	// Only the bits a test provokes may be set
	a_vio_mask : assert property (@(negedge clk) disable iff (!rst_n)
		(o_violation & ~allowed) == '0)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] o_violation: got %h allowed mask %h", o_violation, allowed);
		end

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		if (r < 0)
			r = -r;
		return r % n;
	endfunction

	// Legal codes only, never EXOKAY
	function automatic axil_mon_pkg::resp_t pick_resp();
		int r;
		r = rand_below(3);
		return (r == 0) ? 2'b00 : ((r == 1) ? 2'b10 : 2'b11);
	endfunction

	task automatic idle_all();
		awvalid = 1'b0;
		awready = 1'b0;
		wvalid = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bready = 1'b0;
		arvalid = 1'b0;
		arready = 1'b0;
		rvalid = 1'b0;
		rready = 1'b0;
	endtask

	// Ends on the falling edge where reset is released
	task automatic pulse_reset();
		@(negedge clk);
		idle_all();
		tb_rst_n = 1'b0;
		repeat (5) @(negedge clk);
		allowed = '0;
		tb_rst_n = 1'b1;
	endtask

	task automatic send_aw(input int stall);
		awvalid = 1'b1;
		awaddr = axil_mon_pkg::addr_t'($random(seed));
		awprot = axil_mon_pkg::prot_t'($random(seed));
		repeat (stall) @(negedge clk);
		awready = 1'b1;
		@(negedge clk);
		awvalid = 1'b0;
		awready = 1'b0;
	endtask

	task automatic send_w(input int stall);
		wvalid = 1'b1;
		wdata = $random(seed);
		wstrb = axil_mon_pkg::strb_t'($random(seed));
		repeat (stall) @(negedge clk);
		wready = 1'b1;
		@(negedge clk);
		wvalid = 1'b0;
		wready = 1'b0;
	endtask

	task automatic send_ar(input int stall);
		arvalid = 1'b1;
		araddr = axil_mon_pkg::addr_t'($random(seed));
		arprot = axil_mon_pkg::prot_t'($random(seed));
		repeat (stall) @(negedge clk);
		arready = 1'b1;
		@(negedge clk);
		arvalid = 1'b0;
		arready = 1'b0;
	endtask

	task automatic resp_b(input int delay, input int stall);
		repeat (delay) @(negedge clk);
		bvalid = 1'b1;
		bresp = pick_resp();
		repeat (stall) @(negedge clk);
		bready = 1'b1;
		@(negedge clk);
		bvalid = 1'b0;
		bready = 1'b0;
	endtask

	task automatic resp_r(input int delay, input int stall);
		repeat (delay) @(negedge clk);
		rvalid = 1'b1;
		rdata = $random(seed);
		rresp = pick_resp();
		repeat (stall) @(negedge clk);
		rready = 1'b1;
		@(negedge clk);
		rvalid = 1'b0;
		rready = 1'b0;
	endtask

	// Bit low for lim-1 edges after the drive edge, high at the lim-th
	task automatic check_exact(input int b, input int lim, input string what);
		repeat (lim - 1) @(negedge clk);
		assert (!o_violation[b])
		else
		begin
			errors = errors + 1;
			$display("%s flagged before its limit cycle", what);
		end
		@(negedge clk);
		assert (o_violation[b])
		else
		begin
			errors = errors + 1;
			$display("%s was not flagged at its limit cycle", what);
		end
	endtask

	// One output must read zero out of reset
	task automatic check_reset_zero(input string name, input logic [31:0] value);
		assert (value == '0)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] %s: got %h expected %h after reset", name, value, 32'h0);
		end
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	initial
	begin
		seed = 31;
		errors = 0;
		allowed = '0;
		tb_rst_n = 1'b1;
		idle_all();
		awaddr = '0;
		awprot = '0;
		wdata = '0;
		wstrb = '0;
		bresp = '0;
		araddr = '0;
		arprot = '0;
		rdata = '0;
		rresp = '0;
		// Reset state
		wait (gen_rst_n);
		@(negedge clk);
		check_reset_zero("o_violation", o_violation);
		check_reset_zero("o_rd_outstanding", o_rd_outstanding);
		check_reset_zero("o_awr_outstanding", o_awr_outstanding);
		check_reset_zero("o_wr_outstanding", o_wr_outstanding);
		// Clean traffic with aw and w order varied
		repeat (40)
		begin
			if (rand_below(2) == 1)
			begin
				if (rand_below(2) == 1)
				begin
					send_aw(rand_below(5));
					send_w(rand_below(5));
				end
				else
				begin
					send_w(rand_below(5));
					send_aw(rand_below(5));
				end
				resp_b(rand_below(5), rand_below(5));
			end
			else
			begin
				send_ar(rand_below(5));
				resp_r(rand_below(5), rand_below(5));
			end
			@(negedge clk);
		end
		// Dropped awvalid while stalled
		pulse_reset();
		@(negedge clk);
		allowed[`VIO_HOLD_AW] = 1'b1;
		awvalid = 1'b1;
		@(negedge clk);
		awvalid = 1'b0;
		check_exact(`VIO_HOLD_AW, 1, "Dropped awvalid");
		// Changed rdata while stalled
		pulse_reset();
		@(negedge clk);
		allowed[`VIO_HOLD_R] = 1'b1;
		send_ar(0);
		rvalid = 1'b1;
		rdata = 32'h1234_5678;
		@(negedge clk);
		rdata = 32'h8765_4321;
		check_exact(`VIO_HOLD_R, 1, "Changed rdata");
		rready = 1'b1;
		@(negedge clk);
		idle_all();
		// EXOKAY response
		pulse_reset();
		@(negedge clk);
		allowed[`VIO_RESP_EXOKAY] = 1'b1;
		send_aw(0);
		send_w(0);
		bvalid = 1'b1;
		bready = 1'b1;
		bresp = 2'b01;
		check_exact(`VIO_RESP_EXOKAY, 1, "EXOKAY response");
		idle_all();
		// Write response without a request
		pulse_reset();
		@(negedge clk);
		allowed[`VIO_ORPHAN_RESP] = 1'b1;
		bvalid = 1'b1;
		bready = 1'b1;
		bresp = 2'b00;
		check_exact(`VIO_ORPHAN_RESP, 1, "Orphan write response");
		idle_all();
		// Valid in the first cycle out of reset
		pulse_reset();
		allowed[`VIO_RESET_VALID] = 1'b1;
		arvalid = 1'b1;
		arready = 1'b1;
		check_exact(`VIO_RESET_VALID, 1, "Valid after reset");
		idle_all();
		resp_r(0, 0);
		// Fourteen reads, then ready at the last legal slot
		pulse_reset();
		@(negedge clk);
		allowed[`VIO_OVERFLOW] = 1'b1;
		allowed[`VIO_RESP_DELAY] = 1'b1;
		arvalid = 1'b1;
		arready = 1'b1;
		repeat (14) @(negedge clk);
		arvalid = 1'b0;
		check_exact(`VIO_OVERFLOW, 1, "Read count overflow");
		arready = 1'b0;
		rvalid = 1'b1;
		rready = 1'b1;
		repeat (14) @(negedge clk);
		idle_all();
		// Read address stall
		pulse_reset();
		@(negedge clk);
		allowed[`VIO_REQ_STALL] = 1'b1;
		arvalid = 1'b1;
		check_exact(`VIO_REQ_STALL, `AXIL_MAXWAIT, "Read address stall");
		arready = 1'b1;
		@(negedge clk);
		idle_all();
		resp_r(0, 0);
		// Write response stall
		pulse_reset();
		@(negedge clk);
		allowed[`VIO_RESP_STALL] = 1'b1;
		send_aw(0);
		send_w(0);
		bvalid = 1'b1;
		check_exact(`VIO_RESP_STALL, `AXIL_MAXRSTALL, "Write response stall");
		bready = 1'b1;
		@(negedge clk);
		idle_all();
		// Unanswered read
		pulse_reset();
		@(negedge clk);
		allowed[`VIO_RESP_DELAY] = 1'b1;
		arvalid = 1'b1;
		arready = 1'b1;
		@(negedge clk);
		idle_all();
		check_exact(`VIO_RESP_DELAY, `AXIL_MAXDELAY, "Read response delay");
		resp_r(0, 0);
		pulse_reset();
		@(negedge clk);
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+rtl
rtl/axil_mon_pkg.sv
rtl/axil_event_if.sv
rtl/axil_channel_watch.sv
rtl/axil_outstanding_track.sv
rtl/axil_timeout_check.sv
rtl/axil_monitor.sv
dv/tb_clk_gen.sv
dv/axil_monitor_tb.sv

// File: Makefile
# Verilator build and run of the AXI-lite monitor testbench

VERILATOR ?= verilator
TOP       ?= axil_monitor_tb
RTL_TOP   ?= axil_monitor
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_STR  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only -Irtl rtl/axil_mon_pkg.sv rtl/axil_event_if.sv \
		rtl/axil_channel_watch.sv rtl/axil_outstanding_track.sv \
		rtl/axil_timeout_check.sv rtl/axil_monitor.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
